// ==== common/wb_cfg.svh ====
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// slot kind codes
`define WB_KIND_NONE  2'd0
`define WB_KIND_REG   2'd1
`define WB_KIND_SEG   2'd2
`define WB_KIND_MEM   2'd3

// write size codes, 3 behaves as dword
`define WB_SIZE_BYTE  2'd0
`define WB_SIZE_WORD  2'd1
`define WB_SIZE_DWORD 2'd2

`define WB_NUM_SLOTS  4
`define WBAQ_DEPTH    4

`define WB_CS_INDEX   3'd1

`endif

// ==== common/wb_pkg.sv ====
package wb_pkg;

    // plain vector widths used across the writeback path
    typedef logic [63:0] data_t;    // one slot result
    typedef logic [31:0] addr_t;    // destination or memory address
    typedef logic [2:0]  reg_idx_t; // index into an 8-entry register file
    typedef logic [1:0]  size_t;    // byte / word / dword code
    typedef logic [1:0]  kind_t;    // none / reg / seg / mem
    typedef logic [31:0] gpr_t;
    typedef logic [15:0] seg_t;

    // one result slot from execute, 99 bits
    typedef struct packed {
        data_t data;
        addr_t dest;
        kind_t kind;
        logic  wb;      // commit flag for this slot
    } wb_slot_t;

    // entry held in the write-address queue, 98 bits
    typedef struct packed {
        addr_t addr;
        data_t data;
        size_t size;
    } mem_write_t;

    // resolved branch info, 35 bits
    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  correct;   // prediction matched
        addr_t target;
    } branch_t;

    // four-phase handshake state of the queue head
    typedef enum logic [1:0] {
        MP_IDLE,
        MP_REQ,
        MP_REL
    } mem_phase_t;

endpackage

// ==== hdl/arch_reg_file.sv ====
`timescale 1ns/1ps
`include "wb_cfg.svh"

module arch_reg_file #(
    parameter int WIDTH = 32
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [`WB_NUM_SLOTS-1:0]             we,
    input  wb_pkg::reg_idx_t [`WB_NUM_SLOTS-1:0] wr_idx,
    input  wb_pkg::data_t [`WB_NUM_SLOTS-1:0]    wr_data,
    input  wb_pkg::size_t                        size,
    input  wb_pkg::reg_idx_t                     rd_idx,

    output logic [WIDTH-1:0]                     rd_data
);

    localparam int NUM_REGS = 8;

    logic [WIDTH-1:0] regs [NUM_REGS];
    logic [WIDTH-1:0] wr_mask;

    // bits a write replaces, the rest keep the old value
    always_comb begin
        case (size)
            `WB_SIZE_BYTE: wr_mask = WIDTH'(8'hff);
            `WB_SIZE_WORD: wr_mask = WIDTH'(16'hffff);
            default:       wr_mask = '1; // dword, also code 3
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later slots override earlier ones on a collision
            for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
                if (we[i]) begin
                    regs[wr_idx[i]] <= (regs[wr_idx[i]] & ~wr_mask)
                                     | (wr_data[i][WIDTH-1:0] & wr_mask);
                end
            end
        end
    end

    assign rd_data = regs[rd_idx]; // decode read port

endmodule

// ==== writeback/writeback_stage.sv ====
`timescale 1ns/1ps
`include "wb_cfg.svh"

module writeback_stage (
    input  logic                                 valid_in,
    input  wb_pkg::wb_slot_t [`WB_NUM_SLOTS-1:0] slots,
    input  wb_pkg::size_t                        size,
    input  logic                                 far_op,
    input  wb_pkg::branch_t                      branch,
    input  wb_pkg::addr_t                        eip_in,
    input  logic                                 ie_in,
    input  logic [2:0]                           ie_type_in,
    input  logic                                 interrupt_in,
    input  logic                                 aq_full,

    output logic                                 stall,
    output logic                                 commit,
    output logic [`WB_NUM_SLOTS-1:0]             gpr_we,
    output logic [`WB_NUM_SLOTS-1:0]             seg_we,
    output wb_pkg::reg_idx_t [`WB_NUM_SLOTS-1:0] wr_idx,
    output wb_pkg::data_t [`WB_NUM_SLOTS-1:0]    wr_data,
    output logic                                 mem_push,
    output wb_pkg::mem_write_t                   mem_wr,
    output wb_pkg::addr_t                        new_eip,
    output logic                                 resteer,
    output logic                                 ie_val,
    output logic [3:0]                           ie_type
);

    wb_pkg::wb_slot_t [`WB_NUM_SLOTS-1:0] eff_slots;
    logic [`WB_NUM_SLOTS-1:0]             mem_hit;
    logic                                 need_mem;
    wb_pkg::addr_t                        taken_eip;

    // far transfer turns slot 0 into a CS load
    always_comb begin
        eff_slots = slots;
        if (far_op) begin
            eff_slots[0].data = {48'd0, slots[0].data[47:32]};
            eff_slots[0].dest = {29'd0, `WB_CS_INDEX};
            eff_slots[0].kind = `WB_KIND_SEG;
            eff_slots[0].wb   = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
            mem_hit[i] = eff_slots[i].wb && (eff_slots[i].kind == `WB_KIND_MEM);
        end
    end

    assign need_mem = |mem_hit;

    // only a memory-writing instruction waits on the queue
    assign stall  = valid_in & need_mem & aq_full;
    assign commit = valid_in & ~stall;

    always_comb begin
        for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
            gpr_we[i]  = commit && eff_slots[i].wb && (eff_slots[i].kind == `WB_KIND_REG);
            seg_we[i]  = commit && eff_slots[i].wb && (eff_slots[i].kind == `WB_KIND_SEG);
            wr_idx[i]  = eff_slots[i].dest[2:0];
            wr_data[i] = eff_slots[i].data;
        end
    end

    // walk downward so the lowest memory slot ends up selected
    always_comb begin
        mem_wr = '0;
        for (int i = `WB_NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                mem_wr.addr = eff_slots[i].dest;
                mem_wr.data = eff_slots[i].data;
            end
        end
        mem_wr.size = size;
    end

    assign mem_push = commit & need_mem;

    assign taken_eip = (branch.valid && branch.taken) ? branch.target : eip_in;
    assign new_eip   = far_op ? slots[0].data[31:0] : taken_eip; // offset half of the pointer

    assign resteer = commit & branch.valid & ~branch.correct;

    // interrupt flag sits above the exception code
    assign ie_val  = ie_in | interrupt_in;
    assign ie_type = {interrupt_in, ie_type_in};

endmodule

// ==== writeback/wbaq.sv ====
`timescale 1ns/1ps
`include "wb_cfg.svh"

module wbaq #(
    parameter int DEPTH = `WBAQ_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  wb_pkg::mem_write_t push_data,
    input  logic               mem_ack,

    output logic               full,
    output logic               mem_req,
    output wb_pkg::mem_write_t mem_out
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    wb_pkg::mem_write_t entries [DEPTH];
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    wb_pkg::mem_phase_t phase;
    logic               do_push;
    logic               do_pop;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CW'(DEPTH));
    assign do_push = push && !full;
    assign do_pop  = (phase == wb_pkg::MP_REL) && !mem_ack; // handshake closed
    assign mem_req = (phase == wb_pkg::MP_REQ);
    assign mem_out = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
        end
    end

    // head entry goes out one four-phase cycle at a time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= wb_pkg::MP_IDLE;
        end else begin
            case (phase)
                wb_pkg::MP_IDLE: begin
                    if (count != '0 && !mem_ack) begin // wait out a stale ack
                        phase <= wb_pkg::MP_REQ;
                    end
                end
                wb_pkg::MP_REQ: begin
                    if (mem_ack) begin
                        phase <= wb_pkg::MP_REL;
                    end
                end
                wb_pkg::MP_REL: begin
                    if (!mem_ack) begin
                        phase <= wb_pkg::MP_IDLE;
                    end
                end
                default: phase <= wb_pkg::MP_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/wb_top.sv ====
`timescale 1ns/1ps
`include "wb_cfg.svh"

module wb_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 valid_in,
    input  wb_pkg::wb_slot_t [`WB_NUM_SLOTS-1:0] slots,
    input  wb_pkg::size_t                        size,
    input  logic                                 far_op,
    input  wb_pkg::branch_t                      branch,
    input  wb_pkg::addr_t                        eip_in,
    input  logic                                 ie_in,
    input  logic [2:0]                           ie_type_in,
    input  logic                                 interrupt_in,
    input  logic                                 mem_ack,
    input  wb_pkg::reg_idx_t                     gpr_rd_idx,
    input  wb_pkg::reg_idx_t                     seg_rd_idx,

    output logic                                 stall,
    output logic                                 mem_req,
    output wb_pkg::mem_write_t                   mem_out,
    output wb_pkg::addr_t                        new_eip,
    output logic                                 resteer,
    output logic                                 ie_val,
    output logic [3:0]                           ie_type,
    output wb_pkg::gpr_t                         gpr_rd_data,
    output wb_pkg::seg_t                         seg_rd_data
);

    logic [`WB_NUM_SLOTS-1:0]             gpr_we;
    logic [`WB_NUM_SLOTS-1:0]             seg_we;
    wb_pkg::reg_idx_t [`WB_NUM_SLOTS-1:0] wr_idx;
    wb_pkg::data_t [`WB_NUM_SLOTS-1:0]    wr_data;
    logic                                 mem_push;
    wb_pkg::mem_write_t                   mem_wr;
    logic                                 aq_full;

    writeback_stage stage_i (
        .valid_in     (valid_in),
        .slots        (slots),
        .size         (size),
        .far_op       (far_op),
        .branch       (branch),
        .eip_in       (eip_in),
        .ie_in        (ie_in),
        .ie_type_in   (ie_type_in),
        .interrupt_in (interrupt_in),
        .aq_full      (aq_full),
        .stall        (stall),
        .commit       (),
        .gpr_we       (gpr_we),
        .seg_we       (seg_we),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .mem_push     (mem_push),
        .mem_wr       (mem_wr),
        .new_eip      (new_eip),
        .resteer      (resteer),
        .ie_val       (ie_val),
        .ie_type      (ie_type)
    );

    wbaq #(.DEPTH(`WBAQ_DEPTH)) wbaq_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (mem_push),
        .push_data (mem_wr),
        .mem_ack   (mem_ack),
        .full      (aq_full),
        .mem_req   (mem_req),
        .mem_out   (mem_out)
    );

    arch_reg_file #(.WIDTH(32)) gpr_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (gpr_we),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .size    (size),
        .rd_idx  (gpr_rd_idx),
        .rd_data (gpr_rd_data)
    );

    arch_reg_file #(.WIDTH(16)) seg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (seg_we),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .size    (`WB_SIZE_DWORD), // segment writes are always full width
        .rd_idx  (seg_rd_idx),
        .rd_data (seg_rd_data)
    );

endmodule

// ==== testbench/tb_mem_responder.sv ====
`timescale 1ns/1ps

module tb_mem_responder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               slow,      // stretch ack delays
    input  logic               mem_req,
    input  wb_pkg::mem_write_t mem_out,

    output logic               mem_ack,
    output logic               done,      // one pulse per finished write
    output wb_pkg::mem_write_t done_data
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT,
        R_HOLD,
        R_DONE
    } resp_state_t;

    resp_state_t        state;
    logic [31:0]        lfsr = 32'hdd08;
    logic [7:0]         wait_cnt;
    logic [7:0]         delay;
    logic               ack_r = 1'b0;
    logic               done_r = 1'b0;
    wb_pkg::mem_write_t captured;

    assign mem_ack = ack_r;
    assign done    = done_r;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw_delay(output logic [7:0] d);
        int nbits;
        nbits = slow ? 4 : 2;
        d = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            d = {d[6:0], lfsr[0]};
        end
        if (slow) begin
            d = d + 8'd8;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            ack_r  <= 1'b0;
            done_r <= 1'b0;
            state  <= R_IDLE;
        end else begin
            done_r <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (mem_req) begin
                        draw_delay(delay);
                        wait_cnt <= delay;
                        captured <= mem_out;
                        state    <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (wait_cnt == 8'd0) begin
                        ack_r <= 1'b1;
                        state <= R_HOLD;
                    end else begin
                        wait_cnt <= wait_cnt - 8'd1;
                    end
                end
                R_HOLD: begin
                    if (!mem_req) begin
                        ack_r <= 1'b0;
                        state <= R_DONE;
                    end
                end
                default: begin
                    // queue pops on this edge
                    done_r    <= 1'b1;
                    done_data <= captured;
                    state     <= R_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== testbench/tb_wb_top.sv ====
`timescale 1ns/1ps
`include "wb_cfg.svh"

module tb_wb_top;

    localparam int N_FAST  = 300;
    localparam int N_SLOW  = 150;
    localparam int HS_MAX  = 30; // slowest handshake, push to pop
    localparam int TIMEOUT = 4 * (N_FAST + N_SLOW) * HS_MAX + `WBAQ_DEPTH * HS_MAX + 16;

    typedef struct packed {
        logic          stall;
        wb_pkg::addr_t new_eip;
        logic          resteer;
        logic          ie_val;
        logic [3:0]    ie_type;
    } expect_t;

    logic                                 clk = 1'b0;
    logic                                 rst_n;
    logic                                 valid_in;
    wb_pkg::wb_slot_t [`WB_NUM_SLOTS-1:0] slots;
    wb_pkg::size_t                        size;
    logic                                 far_op;
    wb_pkg::branch_t                      branch;
    wb_pkg::addr_t                        eip_in;
    logic                                 ie_in;
    logic [2:0]                           ie_type_in;
    logic                                 interrupt_in;
    logic                                 mem_ack;
    wb_pkg::reg_idx_t                     gpr_rd_idx;
    wb_pkg::reg_idx_t                     seg_rd_idx;
    logic                                 stall;
    logic                                 mem_req;
    wb_pkg::mem_write_t                   mem_out;
    wb_pkg::addr_t                        new_eip;
    logic                                 resteer;
    logic                                 ie_val;
    logic [3:0]                           ie_type;
    wb_pkg::gpr_t                         gpr_rd_data;
    wb_pkg::seg_t                         seg_rd_data;

    logic               slow;
    logic               resp_done;
    wb_pkg::mem_write_t resp_data;
    logic [31:0]        lfsr = 32'hdd08;
    wb_pkg::gpr_t       gpr_shadow [8];
    wb_pkg::seg_t       seg_shadow [8];
    wb_pkg::mem_write_t exp_q [$];
    logic               hold = 1'b0;      // current instruction stalled
    logic               req_prev = 1'b0;
    logic [2:0]         rd_cursor = '0;
    int                 cycles = 0;

    always #50 clk = ~clk;

    wb_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .slots        (slots),
        .size         (size),
        .far_op       (far_op),
        .branch       (branch),
        .eip_in       (eip_in),
        .ie_in        (ie_in),
        .ie_type_in   (ie_type_in),
        .interrupt_in (interrupt_in),
        .mem_ack      (mem_ack),
        .gpr_rd_idx   (gpr_rd_idx),
        .seg_rd_idx   (seg_rd_idx),
        .stall        (stall),
        .mem_req      (mem_req),
        .mem_out      (mem_out),
        .new_eip      (new_eip),
        .resteer      (resteer),
        .ie_val       (ie_val),
        .ie_type      (ie_type),
        .gpr_rd_data  (gpr_rd_data),
        .seg_rd_data  (seg_rd_data)
    );

    tb_mem_responder mem_resp_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .slow      (slow),
        .mem_req   (mem_req),
        .mem_out   (mem_out),
        .mem_ack   (mem_ack),
        .done      (resp_done),
        .done_data (resp_data)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(
        input string        name,
        input logic [127:0] got,
        input logic [127:0] exp
    );
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic drive_random_instr();
        wb_pkg::wb_slot_t [`WB_NUM_SLOTS-1:0] s;
        logic [63:0]                          r;
        for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
            rand_bits(64, r);
            s[i].data = r;
            rand_bits(32, r);
            s[i].dest = r[31:0];
            rand_bits(2, r);
            s[i].kind = r[1:0];
            rand_bits(2, r);
            s[i].wb = |r[1:0]; // mostly live slots
        end
        slots <= s;
        rand_bits(35, r);
        branch <= r[34:0];
        rand_bits(2, r);
        valid_in <= |r[1:0];
        rand_bits(2, r);
        size <= r[1:0];
        rand_bits(3, r);
        far_op <= &r[2:0];
        rand_bits(32, r);
        eip_in <= r[31:0];
        rand_bits(3, r);
        ie_in <= &r[2:0];
        rand_bits(3, r);
        ie_type_in <= r[2:0];
        rand_bits(3, r);
        interrupt_in <= &r[2:0];
    endtask

    // expected outputs of one instruction, shadow state advances on commit
    function automatic expect_t model_instr(
        input logic                                 v,
        input wb_pkg::wb_slot_t [`WB_NUM_SLOTS-1:0] s,
        input wb_pkg::size_t                        sz,
        input logic                                 far,
        input wb_pkg::branch_t                      br,
        input wb_pkg::addr_t                        eip,
        input logic                                 ie,
        input logic [2:0]                           iet,
        input logic                                 intr
    );
        expect_t                              e;
        wb_pkg::wb_slot_t [`WB_NUM_SLOTS-1:0] eff;
        wb_pkg::mem_write_t                   mw;
        wb_pkg::reg_idx_t                     idx;
        logic                                 has_mem;
        eff = s;
        mw = '0;
        has_mem = 1'b0;
        if (far) begin
            eff[0].data = {48'd0, s[0].data[47:32]};
            eff[0].dest = {29'd0, `WB_CS_INDEX};
            eff[0].kind = `WB_KIND_SEG;
            eff[0].wb   = 1'b1;
        end
        for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
            if (!has_mem && eff[i].wb && eff[i].kind == `WB_KIND_MEM) begin
                has_mem = 1'b1; // lowest memory slot
                mw.addr = eff[i].dest;
                mw.data = eff[i].data;
                mw.size = sz;
            end
        end
        e.stall   = v && has_mem && (exp_q.size() == `WBAQ_DEPTH);
        e.new_eip = far ? s[0].data[31:0] : ((br.valid && br.taken) ? br.target : eip);
        e.resteer = v && !e.stall && br.valid && !br.correct;
        e.ie_val  = ie || intr;
        e.ie_type = {intr, iet};
        if (v && !e.stall) begin
            for (int i = 0; i < `WB_NUM_SLOTS; i++) begin
                idx = eff[i].dest[2:0];
                if (eff[i].wb && eff[i].kind == `WB_KIND_REG) begin
                    case (sz)
                        `WB_SIZE_BYTE: gpr_shadow[idx][7:0]  = eff[i].data[7:0];
                        `WB_SIZE_WORD: gpr_shadow[idx][15:0] = eff[i].data[15:0];
                        default:       gpr_shadow[idx]       = eff[i].data[31:0];
                    endcase
                end
                if (eff[i].wb && eff[i].kind == `WB_KIND_SEG) begin
                    seg_shadow[idx] = eff[i].data[15:0];
                end
            end
            if (has_mem) begin
                exp_q.push_back(mw);
            end
        end
        return e;
    endfunction

    // outputs settle by the falling edge
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (rst_n) begin
            if (resp_done) begin
                if (exp_q.size() == 0) begin
                    $display("memory write completed while no write was expected");
                    stop_on_failure();
                end else begin
                    check_value("mem_write", resp_data, exp_q.pop_front());
                end
            end
            check_value("gpr_rd_data", gpr_rd_data, gpr_shadow[gpr_rd_idx]);
            check_value("seg_rd_data", seg_rd_data, seg_shadow[seg_rd_idx]);
            check_value("mem_req_under_ack", mem_req && !req_prev && mem_ack, 1'b0);
            req_prev = mem_req;
            e = model_instr(valid_in, slots, size, far_op, branch, eip_in,
                            ie_in, ie_type_in, interrupt_in);
            check_value("stall", stall, e.stall);
            check_value("resteer", resteer, e.resteer);
            if (valid_in) begin
                check_value("new_eip", new_eip, e.new_eip);
                check_value("ie_val", ie_val, e.ie_val);
                check_value("ie_type", ie_type, e.ie_type);
            end
            hold = e.stall;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            stop_on_failure();
        end
    end

    initial begin : stimulus
        int issued;
        for (int r = 0; r < 8; r++) begin
            gpr_shadow[r] = '0;
            seg_shadow[r] = '0;
        end
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        slots        = '0;
        size         = '0;
        far_op       = 1'b0;
        branch       = '0;
        eip_in       = '0;
        ie_in        = 1'b0;
        ie_type_in   = '0;
        interrupt_in = 1'b0;
        gpr_rd_idx   = '0;
        seg_rd_idx   = '0;
        slow         = 1'b0;
        issued       = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        while (issued < N_FAST + N_SLOW) begin
            @(posedge clk);
            gpr_rd_idx <= rd_cursor; // sweep read ports over all registers
            seg_rd_idx <= rd_cursor;
            rd_cursor  <= rd_cursor + 3'd1;
            if (!hold) begin
                slow <= (issued >= N_FAST);
                drive_random_instr();
                issued++;
            end
        end
        @(posedge clk);
        while (hold) @(posedge clk);
        valid_in <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        check_value("mem_req", mem_req, 1'b0);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+common
common/wb_pkg.sv
hdl/arch_reg_file.sv
writeback/writeback_stage.sv
writeback/wbaq.sv
hdl/wb_top.sv
testbench/tb_mem_responder.sv
testbench/tb_wb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_wb_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard common/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
